//--- Makefile
# Verilator build and run for the SPI control register block

VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps
TOP       = spi_ctrl_tb
FILELIST  = build.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(wildcard rtl/*.sv rtl/*.svh tb/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the simulation prints the pass line
run: $(SIM)
	@out="$$(./$(SIM) 2>&1)"; echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- build.f
+incdir+rtl
rtl/spi_regs_pkg.sv
rtl/spi_frame_rx.sv
rtl/ctrl_reg_bank.sv
rtl/periph_spi_mux.sv
rtl/spi_ctrl_top.sv
tb/spi_ctrl_assertions.sv
tb/spi_ctrl_tb.sv

//--- rtl/ctrl_reg_bank.sv
/*
  control register bank
  set/clear/toggle writes to led, dac and adc control, peripheral select
  soft reset and power-up clear, combinational read decode
*/
`timescale 1ns/100ps
`include "spi_regs_cfg.svh"

module ctrl_reg_bank (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       wr_req,
  output logic                       wr_ack,
  input  logic [7:0]                 wr_addr,
  input  logic [7:0]                 wr_data,
  input  logic [7:0]                 rd_addr,
  output logic [7:0]                 rd_data,
  output spi_regs_pkg::ctrl_nibble_t led,
  output spi_regs_pkg::ctrl_nibble_t dac_ctrl,
  output spi_regs_pkg::ctrl_nibble_t adc_ctrl,
  output logic [`NUM_PERIPH-1:0]     spi_sel
);

  logic                       wr_take;
  spi_regs_pkg::ctrl_nibble_t set_bits;
  spi_regs_pkg::ctrl_nibble_t clr_bits;

  // bits in both nibbles toggle, everything else untouched
  // otherwise set first then clear
  function automatic spi_regs_pkg::ctrl_nibble_t apply_set_clr(
    input spi_regs_pkg::ctrl_nibble_t cur,
    input spi_regs_pkg::ctrl_nibble_t set_b,
    input spi_regs_pkg::ctrl_nibble_t clr_b
  );
    spi_regs_pkg::ctrl_nibble_t both;
    both = set_b & clr_b;
    if (both != '0)
      return cur ^ both;
    else
      return (cur | set_b) & ~clr_b;
  endfunction

  // n in 1..NUM_PERIPH picks bit n-1
  // zero or out of range deselects all
  function automatic logic [`NUM_PERIPH-1:0] decode_sel(input logic [7:0] num);
    logic [`NUM_PERIPH-1:0] sel;
    sel = '0;
    for (int i = 0; i < `NUM_PERIPH; i++)
    begin
      if (num == 8'(i + 1))
        sel[i] = 1'b1;
    end
    return sel;
  endfunction

  ////////////////////////////////////////
  // write handshake

  // ack follows req one clk later, so a write is taken once
  assign wr_take  = wr_req & ~wr_ack;
  // low nibble sets, high nibble clears
  assign set_bits = wr_data[`CTRL_BITS-1:0];
  assign clr_bits = wr_data[2*`CTRL_BITS-1:`CTRL_BITS];

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      wr_ack <= 1'b0;
    else
      wr_ack <= wr_req;
  end

  ////////////////////////////////////////
  // registers

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      led      <= '0;
      dac_ctrl <= `DAC_CTRL_RESET;
      adc_ctrl <= '0;
      spi_sel  <= '0;
    end
    else if (wr_take)
    begin
      case (spi_regs_pkg::reg_addr_e'(wr_addr))
        spi_regs_pkg::ADDR_LED:
          led <= apply_set_clr(led, set_bits, clr_bits);
        spi_regs_pkg::ADDR_DAC:
          dac_ctrl <= apply_set_clr(dac_ctrl, set_bits, clr_bits);
        spi_regs_pkg::ADDR_ADC:
          adc_ctrl <= apply_set_clr(adc_ctrl, set_bits, clr_bits);
        spi_regs_pkg::ADDR_SPI_MUX:
          spi_sel <= decode_sel(wr_data);
        spi_regs_pkg::ADDR_SOFT_RST:
        begin
          led      <= '0;
          dac_ctrl <= '0;
          adc_ctrl <= '0;
          spi_sel  <= '0;
        end
        // dac already set up before the rails come on
        spi_regs_pkg::ADDR_POWERUP:
        begin
          led      <= '0;
          adc_ctrl <= '0;
        end
        default:
          ;
      endcase
    end
  end

  ////////////////////////////////////////
  // read decode

  // zero-extended, unmapped addresses read 0
  always_comb
  begin
    case (spi_regs_pkg::reg_addr_e'(rd_addr))
      spi_regs_pkg::ADDR_LED:     rd_data = 8'(led);
      spi_regs_pkg::ADDR_SPI_MUX: rd_data = 8'(spi_sel);
      spi_regs_pkg::ADDR_DAC:     rd_data = 8'(dac_ctrl);
      spi_regs_pkg::ADDR_ADC:     rd_data = 8'(adc_ctrl);
      default:                    rd_data = 8'h00;
    endcase
  end

endmodule

//--- rtl/periph_spi_mux.sv
/*
  peripheral spi router
  select latched between transfers, chip-select and miso muxing on cs2_n
*/
`timescale 1ns/100ps
`include "spi_regs_cfg.svh"

module periph_spi_mux (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   cs2_n,
  input  logic [`NUM_PERIPH-1:0] spi_sel,
  input  logic                   fpga_miso,
  input  logic [`NUM_PERIPH-1:0] periph_miso,
  output logic [`NUM_PERIPH-1:0] periph_cs_n,
  output logic                   miso
);

  logic [`SPI_SYNC_STAGES-1:0] cs2_sync;
  logic                        cs2_s;
  logic [`NUM_PERIPH-1:0]      sel_q;

  ////////////////////////////////////////
  // active select

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cs2_sync <= '1;
      sel_q    <= '0;
    end
    else
    begin
      cs2_sync <= {cs2_sync[`SPI_SYNC_STAGES-2:0], cs2_n};
      // follow the bank only between routed transfers
      if (cs2_s)
        sel_q <= spi_sel;
    end
  end

  assign cs2_s = cs2_sync[`SPI_SYNC_STAGES-1];

  ////////////////////////////////////////
  // routing, straight from the pin

  // cs2 high means not asserted, all peripherals off
  assign periph_cs_n = cs2_n ? '1 : ~sel_q;

  // fpga readback unless a peripheral is routed
  assign miso = cs2_n ? fpga_miso : |(sel_q & periph_miso);

endmodule

//--- rtl/spi_ctrl_top.sv
/*
  spi control register block top
  frame receiver, register bank and peripheral router on the board pins
*/
`timescale 1ns/100ps
`include "spi_regs_cfg.svh"

module spi_ctrl_top (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       sclk,
  input  logic                       cs_n,
  input  logic                       mosi,
  input  logic                       cs2_n,
  output logic                       miso,
  input  logic [`NUM_PERIPH-1:0]     periph_miso,
  output logic [`NUM_PERIPH-1:0]     periph_cs_n,
  output logic [`NUM_PERIPH-1:0]     periph_sclk,
  output logic [`NUM_PERIPH-1:0]     periph_mosi,
  output spi_regs_pkg::ctrl_nibble_t led,
  output spi_regs_pkg::ctrl_nibble_t dac_ctrl,
  output spi_regs_pkg::ctrl_nibble_t adc_ctrl
);

  // write handshake
  logic                   wr_req;
  logic                   wr_ack;
  logic [7:0]             wr_addr;
  logic [7:0]             wr_data;
  // readback path
  logic [7:0]             rd_addr;
  logic [7:0]             rd_data;
  // fpga's own miso before the router
  logic                   fpga_miso;
  logic [`NUM_PERIPH-1:0] spi_sel;

  ////////////////////////////////////////
  // clock and data fan-out

  // not muxed, chip-select alone picks the listener
  assign periph_sclk = {`NUM_PERIPH{sclk}};
  assign periph_mosi = {`NUM_PERIPH{mosi}};

  ////////////////////////////////////////
  // blocks

  spi_frame_rx rx0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .sclk    (sclk),
    .cs_n    (cs_n),
    .mosi    (mosi),
    .miso    (fpga_miso),
    .wr_req  (wr_req),
    .wr_ack  (wr_ack),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  ctrl_reg_bank bank0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr_req   (wr_req),
    .wr_ack   (wr_ack),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data),
    .led      (led),
    .dac_ctrl (dac_ctrl),
    .adc_ctrl (adc_ctrl),
    .spi_sel  (spi_sel)
  );

  // router sits on the board miso pin
  periph_spi_mux mux0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .cs2_n       (cs2_n),
    .spi_sel     (spi_sel),
    .fpga_miso   (fpga_miso),
    .periph_miso (periph_miso),
    .periph_cs_n (periph_cs_n),
    .miso        (miso)
  );

endmodule

//--- rtl/spi_frame_rx.sv
/*
  spi frame receiver, spi mode 0 slave sampled on clk
  shifts in address and value, shifts readback out on miso
  and hands complete 16-bit frames to the register bank
*/
`timescale 1ns/100ps
`include "spi_regs_cfg.svh"

module spi_frame_rx (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       sclk,
  input  logic       cs_n,
  input  logic       mosi,
  output logic       miso,
  output logic       wr_req,
  input  logic       wr_ack,
  output logic [7:0] wr_addr,
  output logic [7:0] wr_data,
  output logic [7:0] rd_addr,
  input  logic [7:0] rd_data
);

  logic [`SPI_SYNC_STAGES-1:0] sclk_sync;
  logic [`SPI_SYNC_STAGES-1:0] cs_sync;
  logic [`SPI_SYNC_STAGES-1:0] mosi_sync;
  logic                        sclk_s;
  logic                        cs_s;
  logic                        mosi_s;
  logic                        sclk_d;
  logic                        cs_d;
  logic                        sclk_rise;
  logic                        sclk_fall;
  logic                        cs_rise;
  logic                        cs_fall;
  logic [`SPI_CNT_BITS-1:0]    bit_cnt;
  logic                        addr_done;
  logic                        frame_ok;
  logic [`SPI_FRAME_BITS-1:0]  rx_shift;
  logic [7:0]                  tx_shift;
  spi_regs_pkg::rx_state_e     state_q;
  spi_regs_pkg::rx_state_e     state_d;

  ////////////////////////////////////////
  // pin synchronizers and edge detect

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sclk_sync <= '0;
      // cs idles high
      cs_sync   <= '1;
      mosi_sync <= '0;
      sclk_d    <= 1'b0;
      cs_d      <= 1'b1;
    end
    else
    begin
      sclk_sync <= {sclk_sync[`SPI_SYNC_STAGES-2:0], sclk};
      cs_sync   <= {cs_sync[`SPI_SYNC_STAGES-2:0], cs_n};
      mosi_sync <= {mosi_sync[`SPI_SYNC_STAGES-2:0], mosi};
      sclk_d    <= sclk_s;
      cs_d      <= cs_s;
    end
  end

  assign sclk_s    = sclk_sync[`SPI_SYNC_STAGES-1];
  assign cs_s      = cs_sync[`SPI_SYNC_STAGES-1];
  assign mosi_s    = mosi_sync[`SPI_SYNC_STAGES-1];
  // mode 0, sample on rise and change on fall
  assign sclk_rise = sclk_s & ~sclk_d;
  assign sclk_fall = ~sclk_s & sclk_d;
  assign cs_rise   = cs_s & ~cs_d;
  assign cs_fall   = ~cs_s & cs_d;

  ////////////////////////////////////////
  // bit counter and input shifter

  // saturates so a long frame never wraps back to 16
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      bit_cnt <= '0;
    else if (cs_fall)
      bit_cnt <= '0;
    else if (!cs_s && sclk_rise && bit_cnt != '1)
      bit_cnt <= bit_cnt + 1'b1;
  end

  // eighth bit arriving on this rise
  assign addr_done = (bit_cnt == `SPI_CNT_BITS'(7));
  assign frame_ok  = (bit_cnt == `SPI_CNT_BITS'(`SPI_FRAME_BITS));

  always_ff @(posedge clk)
  begin
    if (!cs_s && sclk_rise)
      rx_shift <= {rx_shift[`SPI_FRAME_BITS-2:0], mosi_s};
    // address byte held for the bank read decode
    if (!cs_s && sclk_rise && addr_done)
      rd_addr <= {rx_shift[6:0], mosi_s};
    // frame captured for the write handshake
    if (state_q == spi_regs_pkg::SHIFT && cs_rise && frame_ok)
    begin
      wr_addr <= rx_shift[`SPI_FRAME_BITS-1 -: 8];
      wr_data <= rx_shift[7:0];
    end
  end

  ////////////////////////////////////////
  // readback shifter

  // zeros during the address byte, readback loaded after bit 8
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      tx_shift <= '0;
    else if (cs_s)
      tx_shift <= '0;
    else if (sclk_fall)
    begin
      if (bit_cnt == `SPI_CNT_BITS'(8))
        tx_shift <= rd_data;
      else
        tx_shift <= {tx_shift[6:0], 1'b0};
    end
  end

  // msb first
  assign miso = tx_shift[7];

  ////////////////////////////////////////
  // frame fsm and write request

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      spi_regs_pkg::IDLE:
        if (cs_fall)
          state_d = spi_regs_pkg::SHIFT;
      // bad bit count goes straight back to idle
      spi_regs_pkg::SHIFT:
        if (cs_rise)
          state_d = frame_ok ? spi_regs_pkg::REQ : spi_regs_pkg::IDLE;
      spi_regs_pkg::REQ:
        if (wr_ack)
          state_d = spi_regs_pkg::WAIT_ACK_LOW;
      spi_regs_pkg::WAIT_ACK_LOW:
        if (!wr_ack)
          state_d = spi_regs_pkg::IDLE;
      default:
        state_d = spi_regs_pkg::IDLE;
    endcase
  end

  // a frame starting before idle is never seen and so dropped
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state_q <= spi_regs_pkg::IDLE;
    else
      state_q <= state_d;
  end

  assign wr_req = (state_q == spi_regs_pkg::REQ);

endmodule

//--- rtl/spi_regs_cfg.svh
/*
  spi control register block configuration
  frame geometry, synchronizer depth, peripheral count and reset values
*/
`ifndef SPI_REGS_CFG_SVH
`define SPI_REGS_CFG_SVH

// bits per spi frame, address byte then value byte
`define SPI_FRAME_BITS 16

// bit counter width
// wide enough to tell an overlong frame from a good one
`define SPI_CNT_BITS 6

// synchronizer flops on every async spi pin
`define SPI_SYNC_STAGES 2

// routed peripherals behind cs2_n
`define NUM_PERIPH 4

// control register width, set nibble and clear nibble
`define CTRL_BITS 4

// dac held in reset with ldac high until the host configures it
// bits are {rst, uni_bip_b, uni_bip_a, ldac}
`define DAC_CTRL_RESET {`CTRL_BITS{1'b1}}

`endif

//--- rtl/spi_regs_pkg.sv
/*
  spi control register types
  register addresses, control nibble type and receiver states
*/
`include "spi_regs_cfg.svh"

package spi_regs_pkg;

  // register address byte, upper byte of a frame
  typedef enum logic [7:0] {
    // power-up clear, leaves dac and mux alone
    ADDR_POWERUP  = 8'd6,
    ADDR_LED      = 8'd7,
    // number to one-hot peripheral select
    ADDR_SPI_MUX  = 8'd8,
    ADDR_DAC      = 8'd9,
    // soft reset of all registers
    ADDR_SOFT_RST = 8'd11,
    ADDR_ADC      = 8'd14
  } reg_addr_e;

  // one control register, also the set or clear half of a value byte
  typedef logic [`CTRL_BITS-1:0] ctrl_nibble_t;

  // frame receiver fsm
  typedef enum logic [1:0] {
    // waiting for cs_n to fall
    IDLE,
    // cs_n low, bits coming in
    SHIFT,
    // frame held, wr_req high
    REQ,
    // wr_req low, waiting for the bank to drop wr_ack
    WAIT_ACK_LOW
  } rx_state_e;

endpackage

//--- tb/spi_ctrl_assertions.sv
/*
  spi control register block checks
  write handshake rules and the single chip-select rule at the top level
*/
`timescale 1ns/100ps
`include "spi_regs_cfg.svh"

module spi_ctrl_assertions (
  input logic                   clk,
  input logic                   rst_n,
  input logic                   wr_req,
  input logic                   wr_ack,
  input logic [7:0]             wr_addr,
  input logic [`NUM_PERIPH-1:0] periph_cs_n
);

  ////////////////////////////////////////
  // four-phase write handshake

  // request held until the bank answers
  req_held: assert property (@(posedge clk) disable iff (!rst_n)
    wr_req && !wr_ack |=> wr_req)
    else $error("wr_req dropped before wr_ack");

  // address frozen for the whole request
  addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
    wr_req |=> !wr_req || $stable(wr_addr))
    else $error("wr_addr changed while wr_req high");

  // ack only answers a request that is still held
  ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(wr_ack) |-> wr_req)
    else $error("wr_ack rose without wr_req");

  ////////////////////////////////////////
  // peripheral chip-selects

  // at most one peripheral addressed on the board pins
  cs_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(~periph_cs_n))
    else $error("more than one periph_cs_n low");

endmodule

bind spi_ctrl_top spi_ctrl_assertions chk0 (
  .clk         (clk),
  .rst_n       (rst_n),
  .wr_req      (wr_req),
  .wr_ack      (wr_ack),
  .wr_addr     (wr_addr),
  .periph_cs_n (periph_cs_n)
);

//--- tb/spi_ctrl_tb.sv
/*
  spi control register block testbench
  spi master tasks, register model, readback, mux routing and reset checks
*/
`timescale 1ns/100ps
`include "spi_regs_cfg.svh"

module spi_ctrl_tb;

  localparam int CLK_HALF       = 20;
  localparam int SCLK_HALF      = 5;
  localparam int SETTLE_CYCLES  = 8;
  localparam int KIND_REGS      = 0;
  localparam int KIND_READ      = 1;
  localparam int KIND_FANOUT    = 2;
  // per-frame cycles times frames, doubled for margin
  localparam int TIMEOUT_CYCLES = 60 * (`SPI_FRAME_BITS * 10 + 20) * 2;

  logic                       clk;
  logic                       rst_n;
  logic                       sclk;
  logic                       cs_n;
  logic                       mosi;
  logic                       cs2_n;
  logic                       miso;
  logic [`NUM_PERIPH-1:0]     periph_miso;
  logic [`NUM_PERIPH-1:0]     periph_cs_n;
  logic [`NUM_PERIPH-1:0]     periph_sclk;
  logic [`NUM_PERIPH-1:0]     periph_mosi;
  spi_regs_pkg::ctrl_nibble_t led;
  spi_regs_pkg::ctrl_nibble_t dac_ctrl;
  spi_regs_pkg::ctrl_nibble_t adc_ctrl;

  // register model
  spi_regs_pkg::ctrl_nibble_t m_led;
  spi_regs_pkg::ctrl_nibble_t m_dac;
  spi_regs_pkg::ctrl_nibble_t m_adc;
  logic [`NUM_PERIPH-1:0]     m_sel;
  // select as latched by the router
  logic [`NUM_PERIPH-1:0]     m_act;
  logic [31:0]                lfsr_state;
  logic [7:0]                 exp_rd;
  logic [7:0]                 got_rd;
  int                         check_kind;
  int                         cycle_cnt;
  event                       check_ev;

  spi_ctrl_top dut0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .sclk        (sclk),
    .cs_n        (cs_n),
    .mosi        (mosi),
    .cs2_n       (cs2_n),
    .miso        (miso),
    .periph_miso (periph_miso),
    .periph_cs_n (periph_cs_n),
    .periph_sclk (periph_sclk),
    .periph_mosi (periph_mosi),
    .led         (led),
    .dac_ctrl    (dac_ctrl),
    .adc_ctrl    (adc_ctrl)
  );

  initial
  begin
    clk = 1'b0;
    forever
      #CLK_HALF clk = ~clk;
  end

  ////////////////////////////////////////
  // random source and reference model

  // galois lfsr on x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'h8020_0003;
    else
      return s >> 1;
  endfunction

  // one step per bit taken
  function automatic logic [7:0] rand_bits(input int n);
    logic [7:0] v;
    v = 8'h00;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[6:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // toggle mode whenever any bit is in both nibbles
  function automatic spi_regs_pkg::ctrl_nibble_t nibble_update(
    input spi_regs_pkg::ctrl_nibble_t cur,
    input logic [7:0]                 data
  );
    spi_regs_pkg::ctrl_nibble_t nxt;
    logic                       overlap;
    overlap = 1'b0;
    nxt = cur;
    for (int b = 0; b < `CTRL_BITS; b++)
    begin
      if (data[b] && data[b + `CTRL_BITS])
        overlap = 1'b1;
    end
    for (int b = 0; b < `CTRL_BITS; b++)
    begin
      if (overlap)
      begin
        if (data[b] && data[b + `CTRL_BITS])
          nxt[b] = ~cur[b];
      end
      else if (data[b + `CTRL_BITS])
        nxt[b] = 1'b0;
      else if (data[b])
        nxt[b] = 1'b1;
    end
    return nxt;
  endfunction

  function automatic void model_write(input logic [7:0] addr, input logic [7:0] data);
    case (addr)
      spi_regs_pkg::ADDR_LED:
        m_led = nibble_update(m_led, data);
      spi_regs_pkg::ADDR_DAC:
        m_dac = nibble_update(m_dac, data);
      spi_regs_pkg::ADDR_ADC:
        m_adc = nibble_update(m_adc, data);
      // number n picks peripheral n and anything else none
      spi_regs_pkg::ADDR_SPI_MUX:
      begin
        m_sel = '0;
        if (data >= 8'd1 && data <= 8'(`NUM_PERIPH))
          m_sel = `NUM_PERIPH'(1) << (data - 8'd1);
      end
      spi_regs_pkg::ADDR_SOFT_RST:
      begin
        m_led = '0;
        m_dac = '0;
        m_adc = '0;
        m_sel = '0;
      end
      spi_regs_pkg::ADDR_POWERUP:
      begin
        m_led = '0;
        m_adc = '0;
      end
      default:
        ;
    endcase
  endfunction

  // register value before the frame zero-extended
  function automatic logic [7:0] model_read(input logic [7:0] addr);
    logic [7:0] val;
    val = 8'h00;
    case (addr)
      spi_regs_pkg::ADDR_LED:
        val[`CTRL_BITS-1:0] = m_led;
      spi_regs_pkg::ADDR_DAC:
        val[`CTRL_BITS-1:0] = m_dac;
      spi_regs_pkg::ADDR_ADC:
        val[`CTRL_BITS-1:0] = m_adc;
      spi_regs_pkg::ADDR_SPI_MUX:
        val[`NUM_PERIPH-1:0] = m_sel;
      default:
        ;
    endcase
    return val;
  endfunction

  function automatic logic [`NUM_PERIPH-1:0] expected_cs();
    return cs2_n ? {`NUM_PERIPH{1'b1}} : ~m_act;
  endfunction

  // idle fpga miso is 0 between frames
  function automatic logic expected_miso();
    logic bit_out;
    bit_out = 1'b0;
    if (!cs2_n)
    begin
      for (int i = 0; i < `NUM_PERIPH; i++)
      begin
        if (m_act[i] && periph_miso[i])
          bit_out = 1'b1;
      end
    end
    return bit_out;
  endfunction

  ////////////////////////////////////////
  // compare tasks

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic check_nibble(input string name, input spi_regs_pkg::ctrl_nibble_t got,
                              input spi_regs_pkg::ctrl_nibble_t exp);
    if (got !== exp)
      abort_run($sformatf("Error: %s = 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic check_byte(input string name, input logic [7:0] got,
                            input logic [7:0] exp);
    if (got !== exp)
      abort_run($sformatf("Error: %s = 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic check_cs(input string name, input logic [`NUM_PERIPH-1:0] got,
                          input logic [`NUM_PERIPH-1:0] exp);
    if (got !== exp)
      abort_run($sformatf("Error: %s = 0x%h, expected 0x%h", name, got, exp));
  endtask

  // woken at a falling edge when outputs have settled
  initial
  begin
    forever
    begin
      @(check_ev);
      if (check_kind == KIND_READ)
        check_byte("readback", got_rd, exp_rd);
      else if (check_kind == KIND_FANOUT)
      begin
        check_cs("periph_sclk", periph_sclk, {`NUM_PERIPH{sclk}});
        check_cs("periph_mosi", periph_mosi, {`NUM_PERIPH{mosi}});
      end
      else
      begin
        check_nibble("led", led, m_led);
        check_nibble("dac_ctrl", dac_ctrl, m_dac);
        check_nibble("adc_ctrl", adc_ctrl, m_adc);
        check_cs("periph_cs_n", periph_cs_n, expected_cs());
        check_byte("miso", {7'b0, miso}, {7'b0, expected_miso()});
      end
    end
  end

  initial
  begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES)
    begin
      @(posedge clk);
      cycle_cnt++;
    end
    abort_run($sformatf("Timeout: the test did not finish within %0d clk cycles",
                        TIMEOUT_CYCLES));
  end

  ////////////////////////////////////////
  // spi master and sequencing tasks

  task automatic request_check(input int kind);
    check_kind = kind;
    -> check_ev;
    @(negedge clk);
  endtask

  // mode 0 master sampling miso just before each rising sclk
  // fan-out checked once per sclk phase
  task automatic spi_xfer(input int nbits, input logic [31:0] frame,
                          output logic [31:0] rx_bits);
    rx_bits = '0;
    cs_n = 1'b0;
    repeat (SCLK_HALF) @(negedge clk);
    for (int i = nbits - 1; i >= 0; i--)
    begin
      mosi = frame[i];
      repeat (SCLK_HALF - 1) @(negedge clk);
      request_check(KIND_FANOUT);
      rx_bits = {rx_bits[30:0], miso};
      sclk = 1'b1;
      repeat (SCLK_HALF - 1) @(negedge clk);
      request_check(KIND_FANOUT);
      sclk = 1'b0;
    end
    repeat (SCLK_HALF) @(negedge clk);
    cs_n = 1'b1;
    mosi = 1'b0;
  endtask

  task automatic settle_and_check();
    repeat (SETTLE_CYCLES) @(negedge clk);
    if (cs2_n)
      m_act = m_sel;
    request_check(KIND_REGS);
  endtask

  task automatic write_frame(input logic [7:0] addr, input logic [7:0] data);
    logic [31:0] rx_bits;
    spi_xfer(`SPI_FRAME_BITS, {16'h0000, addr, data}, rx_bits);
    model_write(addr, data);
    settle_and_check();
  endtask

  // the value byte is still written after the readback
  task automatic read_frame(input logic [7:0] addr, input logic [7:0] data);
    logic [31:0] rx_bits;
    exp_rd = model_read(addr);
    spi_xfer(`SPI_FRAME_BITS, {16'h0000, addr, data}, rx_bits);
    model_write(addr, data);
    settle_and_check();
    got_rd = rx_bits[7:0];
    request_check(KIND_READ);
  endtask

  task automatic drive_cs2(input logic level);
    cs2_n = level;
    repeat (4) @(negedge clk);
    if (level)
      m_act = m_sel;
  endtask

  task automatic route_check(input logic [`NUM_PERIPH-1:0] pattern);
    periph_miso = pattern;
    @(negedge clk);
    request_check(KIND_REGS);
  endtask

  ////////////////////////////////////////
  // test sequence

  initial
  begin
    logic [7:0]             pick;
    logic [7:0]             addr;
    logic [7:0]             data;
    logic [31:0]            rx_bits;
    logic [`NUM_PERIPH-1:0] one_hot;
    rst_n       = 1'b0;
    sclk        = 1'b0;
    cs_n        = 1'b1;
    mosi        = 1'b0;
    cs2_n       = 1'b1;
    periph_miso = '0;
    lfsr_state  = 32'h315675f7;
    m_led       = '0;
    m_dac       = `DAC_CTRL_RESET;
    m_adc       = '0;
    m_sel       = '0;
    m_act       = '0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    repeat (2) @(negedge clk);
    request_check(KIND_REGS);

    // no peripheral selected out of reset
    drive_cs2(1'b0);
    route_check('1);
    drive_cs2(1'b1);

    // random set/clear/toggle writes
    for (int k = 0; k < 40; k++)
    begin
      pick = rand_bits(2);
      if (pick == 8'd0)
        addr = spi_regs_pkg::ADDR_LED;
      else if (pick == 8'd1)
        addr = spi_regs_pkg::ADDR_DAC;
      else
        addr = spi_regs_pkg::ADDR_ADC;
      data = rand_bits(8);
      write_frame(addr, data);
    end

    // readback with value bytes that leave registers as they are
    read_frame(spi_regs_pkg::ADDR_LED, 8'h00);
    read_frame(spi_regs_pkg::ADDR_DAC, 8'h00);
    read_frame(spi_regs_pkg::ADDR_ADC, 8'h00);
    write_frame(spi_regs_pkg::ADDR_SPI_MUX, 8'd3);
    read_frame(spi_regs_pkg::ADDR_SPI_MUX, 8'd3);
    read_frame(8'h23, 8'h00);

    // wrong bit counts are discarded
    // the last 16 bits shifted in would toggle led or adc if committed
    spi_xfer(12, 32'h0000_07FF, rx_bits);
    settle_and_check();
    spi_xfer(20, 32'h0005_0EFF, rx_bits);
    settle_and_check();

    // each valid select with miso high then low from the routed peripheral
    for (int n = 1; n <= `NUM_PERIPH; n++)
    begin
      one_hot = `NUM_PERIPH'(1) << (n - 1);
      write_frame(spi_regs_pkg::ADDR_SPI_MUX, 8'(n));
      drive_cs2(1'b0);
      route_check(one_hot);
      route_check(~one_hot);
      drive_cs2(1'b1);
    end

    // out of range selects nothing
    write_frame(spi_regs_pkg::ADDR_SPI_MUX, 8'd0);
    drive_cs2(1'b0);
    route_check('1);
    drive_cs2(1'b1);
    write_frame(spi_regs_pkg::ADDR_SPI_MUX, 8'd7);
    drive_cs2(1'b0);
    route_check('1);
    drive_cs2(1'b1);

    // select written mid-transfer waits for cs2_n high
    write_frame(spi_regs_pkg::ADDR_SPI_MUX, 8'd1);
    drive_cs2(1'b0);
    route_check(4'b0001);
    write_frame(spi_regs_pkg::ADDR_SPI_MUX, 8'd3);
    route_check(4'b0100);
    drive_cs2(1'b1);
    drive_cs2(1'b0);
    route_check(4'b0100);
    drive_cs2(1'b1);

    // power-up clear keeps dac and select
    write_frame(spi_regs_pkg::ADDR_LED, 8'h0F);
    write_frame(spi_regs_pkg::ADDR_DAC, 8'h06);
    write_frame(spi_regs_pkg::ADDR_ADC, 8'h03);
    write_frame(spi_regs_pkg::ADDR_SPI_MUX, 8'd2);
    write_frame(spi_regs_pkg::ADDR_POWERUP, 8'h00);
    read_frame(spi_regs_pkg::ADDR_SPI_MUX, 8'd2);

    // soft reset clears everything including the select
    write_frame(spi_regs_pkg::ADDR_SOFT_RST, 8'h00);
    read_frame(spi_regs_pkg::ADDR_SPI_MUX, 8'd0);
    drive_cs2(1'b0);
    route_check('1);
    drive_cs2(1'b1);

    @(negedge clk);
    $display("TESTS PASSED");
    $finish;
  end

endmodule
